/* src/dp_pkg.sv */
/*
 * Packet word format of the data path: data and control bytes,
 * the control codes that frame a packet, and the module header layout.
 */
package dp_pkg;

   localparam int DATA_W = 64;
   localparam int CTRL_W = 8;

   // ----------------------------------------------------------------------
   // Control codes
   // ----------------------------------------------------------------------
   // Module header word
   localparam logic [CTRL_W-1:0] CTRL_HDR  = 8'hff;
   // Body word, anything else nonzero is the byte mask of the last word
   localparam logic [CTRL_W-1:0] CTRL_BODY = 8'h00;

   // One word on a stream link
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [CTRL_W-1:0] ctrl;
   } pkt_word_t;

   // ----------------------------------------------------------------------
   // Module header, carried in the data bits of the first word
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic [7:0]  dst_mask;   // one bit per output port
      logic [7:0]  src_port;
      logic [15:0] word_len;
      logic [15:0] byte_len;
      logic [15:0] reserved;
   } mod_hdr_t;

   // Raw data bits or header fields of the same word
   typedef union packed {
      logic [DATA_W-1:0] raw;
      mod_hdr_t          hdr;
   } hdr_data_u;

endpackage

/* src/port_pkg.sv */
/*
 * Port count of the data path and the types that name a port
 * or a set of ports.
 */
package port_pkg;

   localparam int NUM_PORTS = 4;
   localparam int PORT_W    = $clog2(NUM_PORTS);

   // Port number
   typedef logic [PORT_W-1:0] port_idx_t;

   // One bit per port
   typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

/* src/word_fifo.sv */
`timescale 1ns/1ps
/*
 * Show-ahead FIFO of packet words. The head word sits on dout whenever
 * empty is low and rd pops it. Used for both input and output queues.
 */
module word_fifo #(
   parameter int DEPTH = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wr,
   input  dp_pkg::pkt_word_t din,
   input  logic              rd,
   output dp_pkg::pkt_word_t dout,
   output logic              empty,
   output logic              full
);
   import dp_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   pkt_word_t        mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // Wraps at DEPTH, so DEPTH need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (rd) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign dout  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   // Writers and readers upstream must honour the flags
   a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr && full))
      else $error("word_fifo: write while full");
   a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd && empty))
      else $error("word_fifo: read while empty");

endmodule

/* src/input_arbiter.sv */
`timescale 1ns/1ps
/*
 * Input queues plus a round-robin arbiter that forwards one whole packet
 * at a time and stamps the source port into the module header.
 */
module input_arbiter #(
   parameter int IN_FIFO_DEPTH = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  dp_pkg::pkt_word_t    in_word [port_pkg::NUM_PORTS],
   input  port_pkg::port_mask_t in_wr,
   output port_pkg::port_mask_t in_rdy,
   output dp_pkg::pkt_word_t    arb_word,
   output logic                 arb_wr,
   input  logic                 arb_rdy
);
   import dp_pkg::*;
   import port_pkg::*;

   pkt_word_t  head [NUM_PORTS];
   port_mask_t q_empty;
   port_mask_t q_full;
   port_mask_t q_rd;

   port_idx_t  grant;
   port_idx_t  last_port;
   port_idx_t  next_port;
   logic       busy;
   logic       found;
   logic       pkt_end;
   pkt_word_t  cur;
   hdr_data_u  stamp;

   // ----------------------------------------------------------------------
   // Input queues
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_inq
      word_fifo #(
         .DEPTH(IN_FIFO_DEPTH)
      ) inq (
         .clk   (clk),
         .rst   (rst),
         .wr    (in_wr[i]),
         .din   (in_word[i]),
         .rd    (q_rd[i]),
         .dout  (head[i]),
         .empty (q_empty[i]),
         .full  (q_full[i])
      );
   end

   assign in_rdy = ~q_full;

   // ----------------------------------------------------------------------
   // Round-robin search, starting after the port served last
   // ----------------------------------------------------------------------
   always_comb begin
      next_port = last_port;
      found     = 1'b0;
      for (int k = 1; k <= NUM_PORTS; k++) begin
         if (!found && !q_empty[(int'(last_port) + k) % NUM_PORTS]) begin
            next_port = port_idx_t'((int'(last_port) + k) % NUM_PORTS);
            found     = 1'b1;
         end
      end
   end

   // Forward the granted head word
   assign cur     = head[grant];
   assign arb_wr  = busy && !q_empty[grant] && arb_rdy;
   assign pkt_end = arb_wr && (cur.ctrl != CTRL_HDR) && (cur.ctrl != CTRL_BODY);

   always_comb begin
      q_rd        = '0;
      q_rd[grant] = arb_wr;
   end

   // Source port goes into the header on its way out
   always_comb begin
      stamp.raw          = cur.data;
      stamp.hdr.src_port = 8'(grant);
      arb_word           = cur;
      if (cur.ctrl == CTRL_HDR) begin
         arb_word.data = stamp.raw;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy      <= 1'b0;
         grant     <= '0;
         last_port <= port_idx_t'(NUM_PORTS - 1);
      end else if (!busy) begin
         if (found) begin
            busy  <= 1'b1;
            grant <= next_port;
         end
      end else if (pkt_end) begin
         busy      <= 1'b0;
         last_port <= grant;
      end
   end

   // Every grant opens on a header word
   a_grant_on_hdr: assert property (@(posedge clk) disable iff (rst)
      $rose(busy) |-> cur.ctrl == CTRL_HDR)
      else $error("input_arbiter: grant taken inside a packet");

endmodule

/* src/output_port_lookup.sv */
`timescale 1ns/1ps
/*
 * Output port lookup. Holds each module header until the destination MAC
 * in the next word is seen, then fills in dst_mask and streams the packet.
 */
module output_port_lookup (
   input  logic              clk,
   input  logic              rst,
   input  dp_pkg::pkt_word_t arb_word,
   input  logic              arb_wr,
   output logic              arb_rdy,
   output dp_pkg::pkt_word_t lut_word,
   output logic              lut_wr,
   input  logic              lut_rdy
);
   import dp_pkg::*;
   import port_pkg::*;

   // ST_HOLD: header latched, waiting for the first body word
   typedef enum logic {ST_PASS, ST_HOLD} state_t;

   state_t      state;
   pkt_word_t   hold_q;
   logic        hold_vld;
   pkt_word_t   out_q;
   logic        out_vld;
   logic        out_free;
   logic        advance;
   logic [47:0] dst_mac;
   port_idx_t   src_port;
   port_mask_t  dst_mask;
   hdr_data_u   hdr_in;
   hdr_data_u   hdr_out;
   hdr_data_u   emit_view;
   pkt_word_t   next_out;

   assign out_free = !out_vld || lut_rdy;
   assign lut_wr   = out_vld && lut_rdy;
   assign lut_word = out_q;
   assign arb_rdy  = !hold_vld || out_free;

   // A held header moves on only together with the word behind it
   assign advance = hold_vld && out_free && (state == ST_PASS || arb_wr);

   // ----------------------------------------------------------------------
   // Destination decode
   // ----------------------------------------------------------------------
   assign dst_mac    = arb_word.data[63:16];
   assign hdr_in.raw = hold_q.data;
   assign src_port   = port_idx_t'(hdr_in.hdr.src_port);

   always_comb begin
      if (&dst_mac) begin
         // Broadcast, never back to the source
         dst_mask = ~(port_mask_t'(1) << src_port);
      end else begin
         dst_mask = port_mask_t'(1) << port_idx_t'(dst_mac);
      end
   end

   always_comb begin
      hdr_out              = hdr_in;
      hdr_out.hdr.dst_mask = 8'(dst_mask);
      next_out             = hold_q;
      if (state == ST_HOLD) begin
         next_out.data = hdr_out.raw;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_PASS;
         hold_vld <= 1'b0;
         out_vld  <= 1'b0;
      end else begin
         if (arb_wr) begin
            hold_vld <= 1'b1;
         end else if (advance) begin
            hold_vld <= 1'b0;
         end
         if (advance) begin
            out_vld <= 1'b1;
         end else if (lut_wr) begin
            out_vld <= 1'b0;
         end
         if (arb_wr && arb_word.ctrl == CTRL_HDR) begin
            state <= ST_HOLD;
         end else if (advance) begin
            state <= ST_PASS;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (arb_wr) begin
         hold_q <= arb_word;
      end
      if (advance) begin
         out_q <= next_out;
      end
   end

   assign emit_view.raw = lut_word.data;

   a_hdr_has_dest: assert property (@(posedge clk) disable iff (rst)
      lut_wr && lut_word.ctrl == CTRL_HDR |-> emit_view.hdr.dst_mask[NUM_PORTS-1:0] != '0)
      else $error("output_port_lookup: header sent with empty dst_mask");

endmodule

/* src/output_queues.sv */
`timescale 1ns/1ps
/*
 * Output queues. Each packet is written into the queue of every port in
 * its header's dst_mask; each port then drains on its own out_rdy.
 */
module output_queues #(
   parameter int OUT_FIFO_DEPTH = 32
) (
   input  logic                 clk,
   input  logic                 rst,
   input  dp_pkg::pkt_word_t    lut_word,
   input  logic                 lut_wr,
   output logic                 lut_rdy,
   output dp_pkg::pkt_word_t    out_word [port_pkg::NUM_PORTS],
   output port_pkg::port_mask_t out_wr,
   input  port_pkg::port_mask_t out_rdy
);
   import dp_pkg::*;
   import port_pkg::*;

   hdr_data_u  hdr_view;
   port_mask_t hdr_mask;
   port_mask_t cur_mask;
   port_mask_t sel_mask;
   port_mask_t q_wr;
   port_mask_t q_empty;
   port_mask_t q_full;
   logic       in_pkt;
   logic       is_hdr;
   logic       is_last;

   assign hdr_view.raw = lut_word.data;
   assign hdr_mask     = hdr_view.hdr.dst_mask[NUM_PORTS-1:0];
   assign is_hdr       = (lut_word.ctrl == CTRL_HDR);
   assign is_last      = !is_hdr && (lut_word.ctrl != CTRL_BODY);
   assign sel_mask     = is_hdr ? hdr_mask : cur_mask;
   assign q_wr         = lut_wr ? sel_mask : '0;

   // Next header may go anywhere, so all queues need room between packets
   assign lut_rdy = in_pkt ? !(|(q_full & cur_mask)) : !(|q_full);

   always_ff @(posedge clk) begin
      if (rst) begin
         in_pkt <= 1'b0;
      end else if (lut_wr) begin
         if (is_hdr) begin
            in_pkt <= 1'b1;
         end else if (is_last) begin
            in_pkt <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lut_wr && is_hdr) begin
         cur_mask <= hdr_mask;
      end
   end

   // ----------------------------------------------------------------------
   // Per-port queues, drained independently
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_outq
      word_fifo #(
         .DEPTH(OUT_FIFO_DEPTH)
      ) outq (
         .clk   (clk),
         .rst   (rst),
         .wr    (q_wr[i]),
         .din   (lut_word),
         .rd    (out_wr[i]),
         .dout  (out_word[i]),
         .empty (q_empty[i]),
         .full  (q_full[i])
      );
   end

   assign out_wr = ~q_empty & out_rdy;

   // Lookup must close one packet before the next header
   a_hdr_between_pkts: assert property (@(posedge clk) disable iff (rst)
      lut_wr && is_hdr |-> !in_pkt)
      else $error("output_queues: header inside a packet");

endmodule

/* src/user_data_path.sv */
`timescale 1ns/1ps
/*
 * User data path top level: input arbiter, output port lookup and
 * output queues in a straight pipeline over four ports.
 */
module user_data_path #(
   parameter int IN_FIFO_DEPTH  = 16,
   parameter int OUT_FIFO_DEPTH = 32
) (
   input  logic                 clk,
   input  logic                 rst,
   input  dp_pkg::pkt_word_t    in_word [port_pkg::NUM_PORTS],
   input  port_pkg::port_mask_t in_wr,
   output port_pkg::port_mask_t in_rdy,
   output dp_pkg::pkt_word_t    out_word [port_pkg::NUM_PORTS],
   output port_pkg::port_mask_t out_wr,
   input  port_pkg::port_mask_t out_rdy
);
   import dp_pkg::*;

   // Arbiter to lookup
   pkt_word_t arb_word;
   logic      arb_wr;
   logic      arb_rdy;

   // Lookup to output queues
   pkt_word_t lut_word;
   logic      lut_wr;
   logic      lut_rdy;

   input_arbiter #(
      .IN_FIFO_DEPTH(IN_FIFO_DEPTH)
   ) input_arbiter (
      .clk      (clk),
      .rst      (rst),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .arb_word (arb_word),
      .arb_wr   (arb_wr),
      .arb_rdy  (arb_rdy)
   );

   output_port_lookup output_port_lookup (
      .clk      (clk),
      .rst      (rst),
      .arb_word (arb_word),
      .arb_wr   (arb_wr),
      .arb_rdy  (arb_rdy),
      .lut_word (lut_word),
      .lut_wr   (lut_wr),
      .lut_rdy  (lut_rdy)
   );

   output_queues #(
      .OUT_FIFO_DEPTH(OUT_FIFO_DEPTH)
   ) output_queues (
      .clk      (clk),
      .rst      (rst),
      .lut_word (lut_word),
      .lut_wr   (lut_wr),
      .lut_rdy  (lut_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps
/*
 * Testbench clock and reset. Reset stays high for RST_CYCLES rising edges.
 */
module tb_clock #(
   parameter int PERIOD_NS  = 8,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released just after the last reset edge, like any other input
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
   end

endmodule

/* bench/tb_user_data_path.sv */
`timescale 1ns/1ps
/*
 * Directed tests of the user data path: unicast, broadcast, contention,
 * back-pressure and random traffic, checked against per-port scoreboards.
 */
module tb_user_data_path;
   import dp_pkg::*;
   import port_pkg::*;

   localparam int IN_DEPTH   = 16;
   localparam int OUT_DEPTH  = 32;
   localparam int BP_PKTS    = 8;
   localparam int RAND_PKTS  = 40;
   // Unicast, broadcast, contention, back-pressure, random
   localparam int TOTAL_PKTS = 16 + 4 + 12 + BP_PKTS + RAND_PKTS;
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_PKTS + 1000;
   localparam int DRAIN_CYCLES    = 4000;

   logic        clk;
   logic        rst;
   pkt_word_t   in_word  [NUM_PORTS];
   port_mask_t  in_wr;
   port_mask_t  in_rdy;
   pkt_word_t   out_word [NUM_PORTS];
   port_mask_t  out_wr;
   port_mask_t  out_rdy;

   // Words still to be driven, per input port
   pkt_word_t   tx_q [NUM_PORTS][$];
   // Expected words, one queue per output and source port pair
   pkt_word_t   exp_q [NUM_PORTS*NUM_PORTS][$];

   port_mask_t  out_hold;
   logic        stall_en;
   logic [31:0] pkt_rng;
   logic [31:0] stall_rng;
   port_mask_t  mon_in_pkt;
   port_idx_t   mon_src [NUM_PORTS];
   int          errors;
   int          words_checked;
   int          pkts_sent;

   tb_clock #(
      .PERIOD_NS  (8),
      .RST_CYCLES (4)
   ) clock_gen (
      .clk (clk),
      .rst (rst)
   );

   user_data_path #(
      .IN_FIFO_DEPTH  (IN_DEPTH),
      .OUT_FIFO_DEPTH (OUT_DEPTH)
   ) dut0 (
      .clk      (clk),
      .rst      (rst),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

   // ---------------------------------------------------------------------
   // Helpers
   // ---------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] draw_random();
      pkt_rng = xorshift32(pkt_rng);
      return pkt_rng;
   endfunction

   // Random MAC whose low two bits pick the port
   function automatic logic [47:0] unicast_mac(input int dst);
      logic [31:0] hi;
      logic [31:0] lo;
      hi = draw_random();
      lo = draw_random();
      // One cleared bit keeps it from reading as broadcast
      return {hi[31:1], 1'b0, lo[15:2], 2'(dst)};
   endfunction

   function automatic port_mask_t expected_mask(input port_idx_t src, input logic [47:0] mac);
      port_mask_t m;
      if (mac == 48'hffff_ffff_ffff) begin
         m      = '1;
         m[src] = 1'b0;
      end else begin
         m            = '0;
         m[mac[1:0]]  = 1'b1;
      end
      return m;
   endfunction

   function automatic int pending_words();
      int n;
      n = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         n += tx_q[p].size();
      end
      for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) begin
         n += exp_q[i].size();
      end
      return n;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("Error %0t ns: %s", $time, msg);
   endtask

   // Queues one packet on an input and its expected copies on each output
   task automatic send_packet(input int src, input logic [47:0] mac, input int len,
                              input logic [31:0] pattern);
      int         n;
      int         valid;
      int         blen;
      pkt_word_t  w;
      hdr_data_u  hdr;
      port_mask_t mask;
      pkt_word_t  words [$];
      blen = len;
      // A full last word would carry 0xff and read as a header
      if (blen % 8 == 0) begin
         blen = blen + 1;
      end
      n     = (blen + 7) / 8;
      valid = blen - 8 * (n - 1);
      mask  = expected_mask(port_idx_t'(src), mac);
      hdr.raw          = '0;
      hdr.hdr.word_len = 16'(n);
      hdr.hdr.byte_len = 16'(blen);
      w.data = hdr.raw;
      w.ctrl = CTRL_HDR;
      tx_q[src].push_back(w);
      hdr.hdr.src_port = 8'(src);
      hdr.hdr.dst_mask = 8'(mask);
      w.data = hdr.raw;
      words.push_back(w);
      for (int i = 0; i < n; i++) begin
         if (i == 0) begin
            w.data = {mac, pattern[15:0]};
         end else begin
            w.data = {pattern ^ 32'(i), 16'(blen), 8'(src), 8'(i)};
         end
         // Last word marks its valid bytes from the top down
         w.ctrl = (i == n - 1) ? 8'(8'hff << (8 - valid)) : CTRL_BODY;
         tx_q[src].push_back(w);
         words.push_back(w);
      end
      for (int d = 0; d < NUM_PORTS; d++) begin
         if (mask[d]) begin
            foreach (words[k]) begin
               exp_q[d * NUM_PORTS + src].push_back(words[k]);
            end
         end
      end
      pkts_sent++;
   endtask

   task automatic check_word(input int p, input pkt_word_t w);
      hdr_data_u h;
      int        key;
      pkt_word_t exp;
      h.raw = w.data;
      if (w.ctrl == CTRL_HDR) begin
         assert (!mon_in_pkt[p])
            else report_error($sformatf("port %0d header inside a packet", p));
         mon_src[p]    = port_idx_t'(h.hdr.src_port);
         mon_in_pkt[p] = 1'b1;
      end else begin
         assert (mon_in_pkt[p])
            else report_error($sformatf("port %0d word outside a packet", p));
      end
      key = p * NUM_PORTS + int'(mon_src[p]);
      assert (exp_q[key].size() > 0)
         else report_error($sformatf("port %0d unexpected word %h", p, w));
      if (exp_q[key].size() > 0) begin
         exp = exp_q[key].pop_front();
         words_checked++;
         assert (w == exp)
            else report_error($sformatf("port %0d got %h expected %h", p, w, exp));
      end
      if (w.ctrl != CTRL_HDR && w.ctrl != CTRL_BODY) begin
         mon_in_pkt[p] = 1'b0;
      end
   endtask

   task automatic wait_drain(input string name);
      int cycles;
      cycles = 0;
      while (pending_words() > 0 && cycles < DRAIN_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      assert (pending_words() == 0)
         else begin
            errors++;
            $display("%s test: %0d words never came out", name, pending_words());
            for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) begin
               exp_q[i].delete();
            end
         end
      // Room for stray words to show up
      repeat (20) @(posedge clk);
   endtask

   // ---------------------------------------------------------------------
   // Tests
   // ---------------------------------------------------------------------
   task automatic test_unicast();
      for (int s = 0; s < NUM_PORTS; s++) begin
         for (int d = 0; d < NUM_PORTS; d++) begin
            send_packet(s, unicast_mac(d), 14 + 8 * d + s, draw_random());
         end
      end
      wait_drain("unicast");
   endtask

   task automatic test_broadcast();
      for (int s = 0; s < NUM_PORTS; s++) begin
         send_packet(s, 48'hffff_ffff_ffff, 60 + s, draw_random());
      end
      wait_drain("broadcast");
   endtask

   // All inputs at once, mostly into the same output
   task automatic test_contention();
      for (int k = 0; k < 3; k++) begin
         for (int s = 0; s < NUM_PORTS; s++) begin
            send_packet(s, unicast_mac(k % 2), 20 + 11 * k + 3 * s, draw_random());
         end
      end
      wait_drain("contention");
   endtask

   task automatic test_backpressure();
      int cycles;
      out_hold[2] = 1'b1;
      for (int k = 0; k < BP_PKTS; k++) begin
         send_packet(0, unicast_mac(2), 61, draw_random());
      end
      cycles = 0;
      while (in_rdy[0] && cycles < 1000) begin
         @(negedge clk);
         cycles++;
      end
      assert (!in_rdy[0])
         else begin
            errors++;
            $display("Back-pressure test: in_rdy of port 0 never fell");
         end
      repeat (10) @(posedge clk);
      out_hold[2] = 1'b0;
      wait_drain("back-pressure");
   endtask

   task automatic test_random();
      logic [31:0] r;
      logic [47:0] mac;
      int          len;
      stall_en = 1'b1;
      for (int k = 0; k < RAND_PKTS; k++) begin
         r = draw_random();
         if (r[4:2] == 3'b000) begin
            mac = '1;
         end else begin
            mac = unicast_mac(int'(r[6:5]));
         end
         len = 14 + int'(r[15:8]) % 90;
         send_packet(int'(r[1:0]), mac, len, draw_random());
      end
      wait_drain("random");
      stall_en = 1'b0;
   endtask

   // ---------------------------------------------------------------------
   // Stimulus driver, monitor, watchdog
   // ---------------------------------------------------------------------
   initial begin
      in_wr     = '0;
      out_rdy   = '1;
      stall_rng = 32'd76;
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_word[p] = '0;
      end
      forever begin
         @(posedge clk);
         #1;
         for (int p = 0; p < NUM_PORTS; p++) begin
            in_wr[p] = 1'b0;
            if (!rst && in_rdy[p] && tx_q[p].size() > 0) begin
               in_word[p] = tx_q[p].pop_front();
               in_wr[p]   = 1'b1;
            end
         end
         stall_rng = xorshift32(stall_rng);
         for (int p = 0; p < NUM_PORTS; p++) begin
            out_rdy[p] = !out_hold[p] && !(stall_en && stall_rng[p*2 +: 2] == 2'b00);
         end
      end
   end

   // Outputs are settled mid-cycle
   initial begin
      mon_in_pkt = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         mon_src[p] = '0;
      end
      forever begin
         @(negedge clk);
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst && out_wr[p]) begin
               check_word(p, out_word[p]);
            end
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      errors        = 0;
      words_checked = 0;
      pkts_sent     = 0;
      out_hold      = '0;
      stall_en      = 1'b0;
      pkt_rng       = 32'd76;
      wait (rst == 1'b0);
      repeat (2) @(negedge clk);
      assert (in_rdy == '1 && out_wr == '0)
         else report_error($sformatf("after reset in_rdy %b out_wr %b", in_rdy, out_wr));
      test_unicast();
      test_broadcast();
      test_contention();
      test_backpressure();
      test_random();
      $display("Done: %0d packets, %0d words checked, %0d errors",
               pkts_sent, words_checked, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* tb.f */
src/dp_pkg.sv
src/port_pkg.sv
src/word_fifo.sv
src/input_arbiter.sv
src/output_port_lookup.sv
src/output_queues.sv
src/user_data_path.sv
bench/tb_clock.sv
bench/tb_user_data_path.sv

/* run.sh */
#!/bin/sh
# Compile and run the user data path testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_user_data_path -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_user_data_path > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
   exit 1
fi
exit 0
